// File: logic/attn_pkg.sv
// Attention score lane shared definitions
// Fixed-point formats, element types and conversion widths
package attn_pkg;

    // Q, K and V element, Q1.7
    localparam int ELEM_W = 8;
    localparam int ELEM_F = 7;

    // Full product of two elements, Q2.14
    localparam int IPROD_W = 2 * ELEM_W;
    localparam int IPROD_F = 2 * ELEM_F;

    // Narrowed product entering the tree, Q2.10
    localparam int PROD_W = 12;
    localparam int PROD_F = 10;

    // Largest dimension the tree sum has headroom for
    localparam int MAX_EMBED_DIM = 16;

    // Tree sum, Q6.10
    // One extra integer bit per tree level
    localparam int DOT_W = PROD_W + $clog2(MAX_EMBED_DIM);
    localparam int DOT_F = PROD_F;

    // Output score, Q4.8
    localparam int SCORE_W = 12;
    localparam int SCORE_F = 8;

    // Divide by sqrt(64) for an assumed dimension of 64
    localparam int SCALE_SHIFT = 3;

    // Element of any operand vector
    typedef logic signed [ELEM_W-1:0] elem_t;

    // Product after narrowing
    typedef logic signed [PROD_W-1:0] prod_t;

    // Adder tree node and final sum
    typedef logic signed [DOT_W-1:0] dot_t;

    // Saturated, scaled score
    typedef logic signed [SCORE_W-1:0] score_t;

endpackage

// File: logic/operand_if.sv
// Operand control link between score control and the datapath
// Carries operand register loads and the tree entry handshake
`timescale 1ns/1ns

interface operand_if;

    // Capture strobes for the operand registers
    logic load_q;
    logic load_k;
    logic load_v;

    // Q, K and V all held, row ready for the tree
    logic operand_vld;

    // Tree first stage accepts this cycle
    logic tree_rdy;

    modport ctrl (
        output load_q, load_k, load_v, operand_vld,
        input  tree_rdy
    );

    modport data (
        input  load_q, load_k, load_v, operand_vld,
        output tree_rdy
    );

endinterface

// File: logic/q_convert.sv
// Fixed-point format converter
// Floors away fraction bits, then saturates to the output range
`timescale 1ns/1ns

module q_convert #(
    parameter int IN_W  = 16,
    parameter int IN_F  = 14,
    parameter int OUT_W = 12,
    parameter int OUT_F = 10
) (
    input  logic signed [IN_W-1:0]  in,
    output logic signed [OUT_W-1:0] out
);

    // Fraction bits dropped
    localparam int SHIFT = IN_F - OUT_F;

    // Output limits at input width
    localparam logic signed [IN_W-1:0] HI = IN_W'((1 << (OUT_W - 1)) - 1);
    // Two's complement, most negative is ~most positive
    localparam logic signed [IN_W-1:0] LO = ~HI;

    logic signed [IN_W-1:0] floored;

    // Arithmetic shift rounds toward minus infinity
    assign floored = in >>> SHIFT;

    always_comb begin
        if (floored > HI) begin
            out = HI[OUT_W-1:0];
        end else if (floored < LO) begin
            out = LO[OUT_W-1:0];
        end else begin
            // In range, low bits carry the value
            out = floored[OUT_W-1:0];
        end
    end

endmodule

// File: logic/tree_reduce.sv
// Pipelined adder tree with per-stage valid/ready stall
// A payload rides alongside the sum through every stage
`timescale 1ns/1ns

module tree_reduce #(
    parameter int EMBED_DIM = 16,
    parameter int PAYLOAD_W = 128
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vld_in,
    output logic                 rdy_out,
    output logic                 vld_out,
    input  logic                 rdy_in,
    input  attn_pkg::prod_t      terms [EMBED_DIM],
    input  logic [PAYLOAD_W-1:0] payload_in,
    output attn_pkg::dot_t       sum,
    output logic [PAYLOAD_W-1:0] payload_out
);

    localparam int STAGES = $clog2(EMBED_DIM);

    // Heap order, node 0 is the root, children of n at 2n+1 and 2n+2
    attn_pkg::dot_t node [EMBED_DIM-1];

    // Per level state, level 0 feeds the output
    logic                 vld     [STAGES];
    logic                 adv     [STAGES];
    logic                 src_vld [STAGES];
    logic [PAYLOAD_W-1:0] pay     [STAGES];
    logic [PAYLOAD_W-1:0] src_pay [STAGES];

    for (genvar l = 0; l < STAGES; l++) begin : g_lvl
        // Deepest level takes the tree input
        if (l == STAGES - 1) begin : g_entry
            assign src_vld[l] = vld_in;
            assign src_pay[l] = payload_in;
        end else begin : g_inner
            assign src_vld[l] = vld[l+1];
            assign src_pay[l] = pay[l+1];
        end

        // Advance when empty or the next level moves on
        if (l == 0) begin : g_out
            assign adv[l] = !vld[l] || rdy_in;
        end else begin : g_chain
            assign adv[l] = !vld[l] || adv[l-1];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                vld[l] <= 1'b0;
            end else if (adv[l]) begin
                vld[l] <= src_vld[l];
            end
        end

        always_ff @(posedge clk) begin
            if (adv[l] && src_vld[l]) begin
                pay[l] <= src_pay[l];
            end
        end
    end

    for (genvar n = 0; n < EMBED_DIM - 1; n++) begin : g_node
        localparam int LVL = $clog2(n + 2) - 1;

        attn_pkg::dot_t lhs;
        attn_pkg::dot_t rhs;

        // Bottom nodes add sign-extended products directly
        if (LVL == STAGES - 1) begin : g_leaf
            assign lhs = attn_pkg::dot_t'(terms[2*n + 1 - (EMBED_DIM - 1)]);
            assign rhs = attn_pkg::dot_t'(terms[2*n + 2 - (EMBED_DIM - 1)]);
        end else begin : g_sum
            assign lhs = node[2*n + 1];
            assign rhs = node[2*n + 2];
        end

        always_ff @(posedge clk) begin
            if (adv[LVL] && src_vld[LVL]) begin
                node[n] <= lhs + rhs;
            end
        end
    end

    assign rdy_out     = adv[STAGES-1];
    assign vld_out     = vld[0];
    assign sum         = node[0];
    assign payload_out = pay[0];

endmodule

// File: logic/score_ctrl.sv
// Score lane control
// Operand held flags, Q row counter and the input ready outputs
`timescale 1ns/1ns

module score_ctrl #(
    parameter int SEQ_LEN = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    q_vld,
    input  logic    k_vld,
    input  logic    v_vld,
    output logic    q_rdy,
    output logic    k_rdy,
    output logic    v_rdy,
    operand_if.ctrl ops
);

    // At least one bit even for a single row
    localparam int CNT_W = (SEQ_LEN > 1) ? $clog2(SEQ_LEN) : 1;

    logic             q_held;
    logic             k_held;
    logic             v_held;
    logic [CNT_W-1:0] row_cnt;
    logic             fire;
    logic             last_row;

    assign ops.operand_vld = q_held && k_held && v_held;

    // Row enters the tree
    assign fire     = ops.operand_vld && ops.tree_rdy;
    assign last_row = (row_cnt == '0);

    // Q stays until its last row fires, K and V turn over every row
    assign q_rdy = !q_held || (fire && last_row);
    assign k_rdy = !k_held || fire;
    assign v_rdy = !v_held || fire;

    assign ops.load_q = q_vld && q_rdy;
    assign ops.load_k = k_vld && k_rdy;
    assign ops.load_v = v_vld && v_rdy;

    // Q flag and rows left on it
    always_ff @(posedge clk) begin
        if (rst) begin
            q_held  <= 1'b0;
            row_cnt <= '0;
        end else if (ops.load_q) begin
            // New Q may arrive on the old one's final fire
            q_held  <= 1'b1;
            row_cnt <= CNT_W'(SEQ_LEN - 1);
        end else if (fire) begin
            if (last_row) begin
                q_held <= 1'b0;
            end else begin
                row_cnt <= row_cnt - 1'b1;
            end
        end
    end

    // K and V flags, load wins over release
    always_ff @(posedge clk) begin
        if (rst) begin
            k_held <= 1'b0;
            v_held <= 1'b0;
        end else begin
            if (ops.load_k) begin
                k_held <= 1'b1;
            end else if (fire) begin
                k_held <= 1'b0;
            end
            if (ops.load_v) begin
                v_held <= 1'b1;
            end else if (fire) begin
                v_held <= 1'b0;
            end
        end
    end

endmodule

// File: logic/dot_product.sv
// Q.K dot product datapath
// Operand registers, multipliers, product narrowing, adder tree, score scaling
`timescale 1ns/1ns

module dot_product #(
    parameter int EMBED_DIM = 16
) (
    input  logic            clk,
    input  logic            rst,
    operand_if.data         ops,
    input  attn_pkg::elem_t q_in [EMBED_DIM],
    input  attn_pkg::elem_t k_in [EMBED_DIM],
    input  attn_pkg::elem_t v_in [EMBED_DIM],
    input  logic            score_rdy,
    output logic            score_vld,
    output attn_pkg::score_t score,
    output attn_pkg::elem_t v_out [EMBED_DIM]
);

    localparam int PAYLOAD_W = EMBED_DIM * attn_pkg::ELEM_W;

    attn_pkg::elem_t                              q_reg [EMBED_DIM];
    attn_pkg::elem_t                              k_reg [EMBED_DIM];
    // V packed so it can ride the tree as one payload word
    attn_pkg::elem_t [EMBED_DIM-1:0]              v_reg;
    attn_pkg::elem_t [EMBED_DIM-1:0]              v_pay;
    logic signed [attn_pkg::IPROD_W-1:0]          iprod [EMBED_DIM];
    attn_pkg::prod_t                              prod  [EMBED_DIM];
    attn_pkg::dot_t                               sum;
    attn_pkg::score_t                             score_sat;

    // Operand capture on handshake
    always_ff @(posedge clk) begin
        for (int i = 0; i < EMBED_DIM; i++) begin
            if (ops.load_q) begin
                q_reg[i] <= q_in[i];
            end
            if (ops.load_k) begin
                k_reg[i] <= k_in[i];
            end
            if (ops.load_v) begin
                v_reg[i] <= v_in[i];
            end
        end
    end

    for (genvar i = 0; i < EMBED_DIM; i++) begin : g_lane
        // Q1.7 times Q1.7 gives Q2.14
        assign iprod[i] = q_reg[i] * k_reg[i];

        // Narrow to Q2.10
        q_convert #(
            .IN_W  (attn_pkg::IPROD_W),
            .IN_F  (attn_pkg::IPROD_F),
            .OUT_W (attn_pkg::PROD_W),
            .OUT_F (attn_pkg::PROD_F)
        ) prod_conv_inst (
            .in  (iprod[i]),
            .out (prod[i])
        );

        assign v_out[i] = v_pay[i];
    end

    tree_reduce #(
        .EMBED_DIM (EMBED_DIM),
        .PAYLOAD_W (PAYLOAD_W)
    ) tree_inst (
        .clk         (clk),
        .rst         (rst),
        .vld_in      (ops.operand_vld),
        .rdy_out     (ops.tree_rdy),
        .vld_out     (score_vld),
        .rdy_in      (score_rdy),
        .terms       (prod),
        .payload_in  (v_reg),
        .sum         (sum),
        .payload_out (v_pay)
    );

    // Q6.10 down to Q4.8, floor and clamp
    q_convert #(
        .IN_W  (attn_pkg::DOT_W),
        .IN_F  (attn_pkg::DOT_F),
        .OUT_W (attn_pkg::SCORE_W),
        .OUT_F (attn_pkg::SCORE_F)
    ) score_conv_inst (
        .in  (sum),
        .out (score_sat)
    );

    // Scale after saturation, 1/sqrt(dk)
    assign score = score_sat >>> attn_pkg::SCALE_SHIFT;

endmodule

// File: logic/score_unit.sv
// Attention score lane top level
// Flat bus ports around score control and the dot product datapath
`timescale 1ns/1ns

module score_unit #(
    parameter int EMBED_DIM = 16,
    parameter int SEQ_LEN   = 4
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    q_vld,
    input  logic                                    k_vld,
    input  logic                                    v_vld,
    output logic                                    q_rdy,
    output logic                                    k_rdy,
    output logic                                    v_rdy,
    input  logic [EMBED_DIM*attn_pkg::ELEM_W-1:0]   q_in,
    input  logic [EMBED_DIM*attn_pkg::ELEM_W-1:0]   k_in,
    input  logic [EMBED_DIM*attn_pkg::ELEM_W-1:0]   v_in,
    input  logic                                    score_rdy,
    output logic                                    score_vld,
    output logic [attn_pkg::SCORE_W-1:0]            score,
    output logic [EMBED_DIM*attn_pkg::ELEM_W-1:0]   v_out
);

    localparam int EW = attn_pkg::ELEM_W;

    attn_pkg::elem_t q_arr [EMBED_DIM];
    attn_pkg::elem_t k_arr [EMBED_DIM];
    attn_pkg::elem_t v_arr [EMBED_DIM];
    attn_pkg::elem_t v_res [EMBED_DIM];

    // Element 0 sits in the low bits
    for (genvar i = 0; i < EMBED_DIM; i++) begin : g_bus
        assign q_arr[i]          = q_in[i*EW +: EW];
        assign k_arr[i]          = k_in[i*EW +: EW];
        assign v_arr[i]          = v_in[i*EW +: EW];
        assign v_out[i*EW +: EW] = v_res[i];
    end

    operand_if ops_if ();

    score_ctrl #(
        .SEQ_LEN (SEQ_LEN)
    ) ctrl_inst (
        .clk   (clk),
        .rst   (rst),
        .q_vld (q_vld),
        .k_vld (k_vld),
        .v_vld (v_vld),
        .q_rdy (q_rdy),
        .k_rdy (k_rdy),
        .v_rdy (v_rdy),
        .ops   (ops_if.ctrl)
    );

    dot_product #(
        .EMBED_DIM (EMBED_DIM)
    ) dot_inst (
        .clk       (clk),
        .rst       (rst),
        .ops       (ops_if.data),
        .q_in      (q_arr),
        .k_in      (k_arr),
        .v_in      (v_arr),
        .score_rdy (score_rdy),
        .score_vld (score_vld),
        .score     (score),
        .v_out     (v_res)
    );

endmodule

// File: verif/score_unit_tb.sv
// Testbench for the attention score lane
// Table-driven Q/K/V rows checked against the fixed-point score rule
`timescale 1ns/1ns

module score_unit_tb;

    localparam int EMBED_DIM    = 16;
    localparam int SEQ_LEN      = 4;
    localparam int EW           = attn_pkg::ELEM_W;
    localparam int VEC_W        = EMBED_DIM * EW;
    localparam int N_GROUPS     = 4;
    localparam int N_ROWS       = N_GROUPS * SEQ_LEN;
    localparam int TREE_DEPTH   = $clog2(EMBED_DIM);
    localparam int RESET_CYCLES = 16;
    // Rows received while score_rdy is held high
    localparam int STEADY_ROWS  = 2 * SEQ_LEN;
    localparam int TIMEOUT      = 2 * (N_ROWS * 4 + TREE_DEPTH + RESET_CYCLES);
    localparam int SCORE_MAX    = (1 << (attn_pkg::SCORE_W - 1)) - 1;
    localparam int SCORE_MIN    = -(1 << (attn_pkg::SCORE_W - 1));

    logic                         clk;
    logic                         rst;
    logic                         q_vld;
    logic                         k_vld;
    logic                         v_vld;
    logic                         q_rdy;
    logic                         k_rdy;
    logic                         v_rdy;
    logic [VEC_W-1:0]             q_in;
    logic [VEC_W-1:0]             k_in;
    logic [VEC_W-1:0]             v_in;
    logic                         score_rdy;
    logic                         score_vld;
    logic [attn_pkg::SCORE_W-1:0] score;
    logic [VEC_W-1:0]             v_out;

    // Stimulus and expected table, one Q per group of rows
    logic [VEC_W-1:0]             q_tab   [N_GROUPS];
    logic [VEC_W-1:0]             k_tab   [N_ROWS];
    logic [VEC_W-1:0]             v_tab   [N_ROWS];
    logic [attn_pkg::SCORE_W-1:0] exp_tab [N_ROWS];
    int                           k_cyc   [N_ROWS];
    int                           pend_q  [$];
    int                           seed;
    int                           cyc;
    int                           timeout_cnt;
    int                           errors;
    int                           checks;
    int                           q_xfer;
    int                           k_xfer;
    int                           rx_cnt;
    int                           last_out;

    score_unit #(
        .EMBED_DIM (EMBED_DIM),
        .SEQ_LEN   (SEQ_LEN)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .q_vld     (q_vld),
        .k_vld     (k_vld),
        .v_vld     (v_vld),
        .q_rdy     (q_rdy),
        .k_rdy     (k_rdy),
        .v_rdy     (v_rdy),
        .q_in      (q_in),
        .k_in      (k_in),
        .v_in      (v_in),
        .score_rdy (score_rdy),
        .score_vld (score_vld),
        .score     (score),
        .v_out     (v_out)
    );

    always #2 clk = ~clk;

    // Every element set to one value
    function automatic logic [VEC_W-1:0] splat(input logic [EW-1:0] e);
        return {EMBED_DIM{e}};
    endfunction

    function automatic logic [VEC_W-1:0] rand_vec();
        logic [VEC_W-1:0] v;
        for (int i = 0; i < EMBED_DIM; i++) begin
            v[i*EW +: EW] = EW'($random(seed));
        end
        return v;
    endfunction

    // Floor products to Q2.10, sum, floor to Q4.8, clamp, then scale
    function automatic int ref_score(input logic [VEC_W-1:0] q, input logic [VEC_W-1:0] k);
        int acc;
        int p;
        int s;
        acc = 0;
        for (int i = 0; i < EMBED_DIM; i++) begin
            p = $signed(q[i*EW +: EW]) * $signed(k[i*EW +: EW]);
            acc += p >>> (attn_pkg::IPROD_F - attn_pkg::PROD_F);
        end
        s = acc >>> (attn_pkg::DOT_F - attn_pkg::SCORE_F);
        if (s > SCORE_MAX) begin
            s = SCORE_MAX;
        end else if (s < SCORE_MIN) begin
            s = SCORE_MIN;
        end
        return s >>> attn_pkg::SCALE_SHIFT;
    endfunction

    task automatic check_val(input logic [VEC_W-1:0] got, input logic [VEC_W-1:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic build_table();
        for (int g = 0; g < N_GROUPS; g++) begin
            q_tab[g] = rand_vec();
        end
        for (int r = 0; r < N_ROWS; r++) begin
            k_tab[r] = rand_vec();
            v_tab[r] = rand_vec();
        end
        // Full scale against full scale and against -1
        q_tab[0]  = splat(8'h7f);
        k_tab[0]  = splat(8'h7f);
        k_tab[1]  = splat(8'h80);
        // -1 against -1, then against the smallest step
        q_tab[1]  = splat(8'h80);
        k_tab[4]  = splat(8'h80);
        k_tab[5]  = splat(8'h01);
        // Tiny negative products floor toward minus infinity
        q_tab[3]  = splat(8'h01);
        k_tab[12] = splat(8'hff);
        k_tab[13] = {8{8'h40, 8'hc0}};
        for (int r = 0; r < N_ROWS; r++) begin
            exp_tab[r] = attn_pkg::SCORE_W'(ref_score(q_tab[r / SEQ_LEN], k_tab[r]));
        end
    endtask

    // Output receiver, handshake tracking and score_rdy pattern
    always @(posedge clk) begin
        int idx;
        cyc++;
        if (score_vld && score_rdy) begin
            if (pend_q.size() == 0) begin
                errors++;
                $display("Score came out at %0t ns with no row pending", $time);
            end else begin
                idx = pend_q.pop_front();
                check_val(score, exp_tab[idx], $sformatf("score of row %0d", idx));
                check_val(v_out, v_tab[idx], $sformatf("v_out of row %0d", idx));
                if (idx < STEADY_ROWS) begin
                    // One cycle from K transfer to fire, then the tree depth
                    check_val(cyc - k_cyc[idx], TREE_DEPTH + 1,
                              $sformatf("latency of row %0d", idx));
                    if (idx > 0) begin
                        check_val(cyc - last_out, 1, $sformatf("gap before row %0d", idx));
                    end
                end
                last_out = cyc;
                rx_cnt++;
            end
        end
        // A new Q only after all rows of the old one have fired
        if (q_vld && q_rdy) begin
            check_val(k_xfer, q_xfer * SEQ_LEN, $sformatf("K rows before Q %0d", q_xfer));
            q_xfer++;
        end
        if (k_vld && k_rdy) begin
            k_cyc[k_xfer] = cyc;
            pend_q.push_back(k_xfer);
            k_xfer++;
        end
        if (rx_cnt < STEADY_ROWS) begin
            score_rdy <= 1'b1;
        end else begin
            score_rdy <= 1'($random(seed));
        end
    end

    always @(posedge clk) begin
        timeout_cnt++;
        if (timeout_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, %0d of %0d rows received",
                     timeout_cnt, rx_cnt, N_ROWS);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        seed        = 32'h270a;
        clk         = 1'b0;
        rst         = 1'b1;
        q_vld       = 1'b0;
        k_vld       = 1'b0;
        v_vld       = 1'b0;
        q_in        = '0;
        k_in        = '0;
        v_in        = '0;
        score_rdy   = 1'b1;
        cyc         = 0;
        timeout_cnt = 0;
        errors      = 0;
        checks      = 0;
        q_xfer      = 0;
        k_xfer      = 0;
        rx_cnt      = 0;
        last_out    = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val(q_rdy, 1, "q_rdy after reset");
        check_val(k_rdy, 1, "k_rdy after reset");
        check_val(v_rdy, 1, "v_rdy after reset");
        check_val(score_vld, 0, "score_vld after reset");
        @(posedge clk);
        // Q, K and V streams, each offered back to back
        fork
            begin
                for (int g = 0; g < N_GROUPS; g++) begin
                    q_in  <= q_tab[g];
                    q_vld <= 1'b1;
                    @(posedge clk);
                    while (!q_rdy) @(posedge clk);
                end
                q_vld <= 1'b0;
            end
            begin
                for (int r = 0; r < N_ROWS; r++) begin
                    k_in  <= k_tab[r];
                    k_vld <= 1'b1;
                    @(posedge clk);
                    while (!k_rdy) @(posedge clk);
                end
                k_vld <= 1'b0;
            end
            begin
                for (int r = 0; r < N_ROWS; r++) begin
                    v_in  <= v_tab[r];
                    v_vld <= 1'b1;
                    @(posedge clk);
                    while (!v_rdy) @(posedge clk);
                end
                v_vld <= 1'b0;
            end
        join
        wait (rx_cnt == N_ROWS);
        // Room for any stray extra output
        repeat (TREE_DEPTH + 1) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
logic/attn_pkg.sv
logic/operand_if.sv
logic/q_convert.sv
logic/tree_reduce.sv
logic/score_ctrl.sv
logic/dot_product.sv
logic/score_unit.sv
verif/score_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the score lane simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module score_unit_tb \
    -f list.f \
    -o score_unit_sim

./obj_dir/score_unit_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
